// ==== mmu_pkg.sv ====
package mmu_pkg;

	// ==================================================
	// Sizing
	// ==================================================

	// Pages are 8 kB, so the low 13 address bits pass through translation
	localparam int log_pagesize = 13;
	localparam int tlb_assoc = 3;
	localparam int log_tlb_sets = 4;
	localparam int tlb_sets = 1 << log_tlb_sets;
	// Width of the per-set round-robin replacement pointer
	localparam int rr_bits = $clog2(tlb_assoc);
	localparam int vadr_bits = 32;
	localparam int padr_bits = 32;
	localparam int vpn_bits = vadr_bits - log_pagesize;
	localparam int ppn_bits = padr_bits - log_pagesize;
	// The tag is whatever is left of the VPN above the set index
	localparam int tag_bits = vpn_bits - log_tlb_sets;

	// ==================================================
	// Types
	// ==================================================

	typedef logic [15:0] asid_t;
	typedef logic [7:0] req_id_t;
	typedef logic [padr_bits-1:0] physical_address_t;

	// Virtual address seen as page number and offset
	typedef struct packed {
		logic [vpn_bits-1:0] vpn;
		logic [log_pagesize-1:0] offset;
	} vadr_page_t;

	// Virtual address seen by the TLB as tag, set index and offset
	typedef struct packed {
		logic [tag_bits-1:0] tag;
		logic [log_tlb_sets-1:0] set_idx;
		logic [log_pagesize-1:0] offset;
	} vadr_tlb_t;

	typedef union packed {
		logic [vadr_bits-1:0] raw;
		vadr_page_t page;
		vadr_tlb_t tlbv;
	} virtual_address_t;

	typedef struct packed {
		logic [ppn_bits-1:0] ppn;
		logic valid;
	} pte_t;

	// One TLB way; the set index is implied by where the entry is stored
	typedef struct packed {
		asid_t asid;
		logic [tag_bits-1:0] tag;
		pte_t pte;
	} tlb_entry_t;

	typedef struct packed {
		asid_t asid;
		logic [vpn_bits-1:0] vpn;
		logic [ppn_bits-1:0] ppn;
	} tlb_fill_t;

	typedef struct packed {
		req_id_t id;
		asid_t asid;
		virtual_address_t vadr;
	} tlb_miss_t;

endpackage

// ==== tlb_lookup.sv ====
`timescale 1ns/1ps

module tlb_lookup (
	input logic clk,
	input logic rst,
	input mmu_pkg::virtual_address_t vadr,
	input mmu_pkg::asid_t asid,
	input mmu_pkg::tlb_fill_t fill,
	input logic fill_v,
	input logic flush_v,
	output logic [mmu_pkg::tlb_assoc-1:0] hit,
	output mmu_pkg::tlb_entry_t [mmu_pkg::tlb_assoc-1:0] ways
);
	import mmu_pkg::*;

	// Translations, one row of ways per set
	tlb_entry_t entry_q [tlb_sets][tlb_assoc];
	// Next way to replace, one pointer per set
	logic [rr_bits-1:0] rr_q [tlb_sets];

	virtual_address_t fill_adr;
	logic [log_tlb_sets-1:0] fill_set;
	logic [tag_bits-1:0] fill_tag;
	logic [tlb_assoc-1:0] fill_match;
	logic [rr_bits-1:0] fill_way;
	logic [rr_bits-1:0] fill_next;

	// ==================================================
	// Fill way selection
	// ==================================================

	// The fill carries a bare VPN. Placing it in a virtual address lets the
	// TLB view split it into set index and tag the same way a lookup does
	always_comb begin
		fill_adr = '0;
		fill_adr.page.vpn = fill.vpn;
		fill_set = fill_adr.tlbv.set_idx;
		fill_tag = fill_adr.tlbv.tag;

		// A refill of a translation that is already present overwrites it in
		// place, otherwise two ways of the set could hit on the same address
		for (int w = 0; w < tlb_assoc; w++) begin
			fill_match[w] = entry_q[fill_set][w].pte.valid
				&& entry_q[fill_set][w].tag == fill_tag
				&& entry_q[fill_set][w].asid == fill.asid;
		end

		// Round-robin victim unless an existing copy was found
		fill_way = rr_q[fill_set];
		for (int w = 0; w < tlb_assoc; w++) begin
			if (fill_match[w])
				fill_way = rr_bits'(w);
		end

		// Pointer wraps from the last way back to way 0
		if (rr_q[fill_set] == rr_bits'(tlb_assoc - 1))
			fill_next = '0;
		else
			fill_next = rr_q[fill_set] + 1'b1;
	end

	// ==================================================
	// Storage
	// ==================================================

	// A written entry is visible from the cycle after the fill strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < tlb_sets; s++) begin
				for (int w = 0; w < tlb_assoc; w++)
					entry_q[s][w].pte.valid <= 1'b0;
				rr_q[s] <= '0;
			end
		end else if (flush_v) begin
			// Flush drops every translation in one cycle but keeps the replacement order
			for (int s = 0; s < tlb_sets; s++) begin
				for (int w = 0; w < tlb_assoc; w++)
					entry_q[s][w].pte.valid <= 1'b0;
			end
		end else if (fill_v) begin
			entry_q[fill_set][fill_way].asid <= fill.asid;
			entry_q[fill_set][fill_way].tag <= fill_tag;
			entry_q[fill_set][fill_way].pte.ppn <= fill.ppn;
			entry_q[fill_set][fill_way].pte.valid <= 1'b1;
			// Only a true replacement moves the pointer on
			if (!(|fill_match))
				rr_q[fill_set] <= fill_next;
		end
	end

	// ==================================================
	// Lookup
	// ==================================================

	// All ways of the addressed set are read out together and compared in
	// parallel
	always_comb begin
		for (int w = 0; w < tlb_assoc; w++) begin
			ways[w] = entry_q[vadr.tlbv.set_idx][w];
			// Hit needs a live entry with matching tag and address space
			hit[w] = ways[w].pte.valid
				&& ways[w].tag == vadr.tlbv.tag
				&& ways[w].asid == asid;
		end
	end

	// Fill and flush share the write side and are never issued together
	a_fill_flush: assert property (
		@(posedge clk) disable iff (rst)
		!(fill_v && flush_v)
	);

	// In-place refill keeps each translation in a single way of its set
	a_one_hit: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(hit)
	);

endmodule

// ==== tlb_adr_mux.sv ====
`timescale 1ns/1ps

module tlb_adr_mux (
	input logic clk,
	input logic rst,
	input logic idle,
	input logic paging_en,
	input logic [mmu_pkg::tlb_assoc-1:0] hit,
	input mmu_pkg::tlb_entry_t [mmu_pkg::tlb_assoc-1:0] ways,
	input mmu_pkg::req_id_t id,
	input mmu_pkg::asid_t asid,
	input mmu_pkg::virtual_address_t vadr,
	input logic vadr_v,
	output mmu_pkg::physical_address_t padr,
	output logic padr_v,
	output logic fill_ready,
	output mmu_pkg::tlb_miss_t miss,
	output logic miss_v
);
	import mmu_pkg::*;

	// Page change detection
	logic [vpn_bits-1:0] prev_vpn;
	logic page_changed;
	// Paging transition detection
	logic paging_q;
	logic paging_rise;
	logic paging_fall;
	// Registered outcome
	logic padr_v_q;
	logic miss_q;
	physical_address_t xlat_adr;
	logic lookup_ok;

	// ==================================================
	// Change and edge detection
	// ==================================================

	// A new page needs one cycle for the TLB read to settle on the new set,
	// so a miss must not be raised while the VPN differs from last cycle.
	// Moving around inside a page does not count as a change
	assign page_changed = vadr.page.vpn != prev_vpn;

	// The address is briefly meaningless as paging switches on or off
	assign paging_rise = paging_en && !paging_q;
	assign paging_fall = !paging_en && paging_q;

	// ==================================================
	// Address selection
	// ==================================================

	// At most one way hits, so the chosen PPN is unambiguous.
	// The page offset is never translated
	always_comb begin
		xlat_adr = '0;
		for (int w = 0; w < tlb_assoc; w++) begin
			if (hit[w])
				xlat_adr = {ways[w].pte.ppn, vadr.page.offset};
		end
	end

	// A usable translation is a live request that hit on a page that has settled
	assign lookup_ok = (|hit) && vadr_v && !page_changed;

	// Payload path follows the input every cycle
	always_ff @(posedge clk) begin
		if (paging_en)
			padr <= xlat_adr;
		else
			padr <= vadr.raw;
		// Every cycle without a usable translation records the would-be fault
		if (paging_en && !lookup_ok) begin
			miss.id <= id;
			miss.asid <= asid;
			miss.vadr <= vadr;
		end
	end

	// Control path
	always_ff @(posedge clk) begin
		if (rst) begin
			prev_vpn <= '0;
			paging_q <= 1'b0;
			padr_v_q <= 1'b0;
			miss_q <= 1'b0;
			fill_ready <= 1'b1;
		end else begin
			prev_vpn <= vadr.page.vpn;
			paging_q <= paging_en;
			if (paging_en) begin
				padr_v_q <= lookup_ok;
				// Only a real request on a settled page can fault
				miss_q <= vadr_v && !page_changed && !lookup_ok;
				// TLB may be written after a hit, or when no lookup is in flight
				fill_ready <= (lookup_ok || !vadr_v) && idle;
			end else begin
				// Pass-through, except right after paging has been dropped
				padr_v_q <= vadr_v && !paging_fall;
				miss_q <= 1'b0;
				fill_ready <= idle;
			end
		end
	end

	// The registered valid still reflects the pass-through cycle when paging
	// has just come on, so it is masked for that one cycle
	assign padr_v = padr_v_q && !paging_rise;

	// A stale miss from the previous page is hidden while the page moves
	assign miss_v = miss_q && !page_changed;

	// A request ends with exactly one of the two outcomes
	a_padr_miss_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(padr_v && miss_v)
	);

	// A miss is never raised while paging is off
	a_miss_paging: assert property (
		@(posedge clk) disable iff (rst)
		$rose(miss_v) |-> paging_en
	);

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top (
	input logic clk,
	input logic rst,
	input mmu_pkg::virtual_address_t vadr,
	input logic vadr_v,
	input mmu_pkg::asid_t asid,
	input mmu_pkg::req_id_t id,
	input logic paging_en,
	input logic idle,
	input mmu_pkg::tlb_fill_t fill,
	input logic fill_v,
	input logic flush_v,
	output mmu_pkg::physical_address_t padr,
	output logic padr_v,
	output mmu_pkg::tlb_miss_t miss,
	output logic miss_v,
	output logic fill_ready
);
	import mmu_pkg::*;

	// Per-way hit flags and the ways of the addressed set
	logic [tlb_assoc-1:0] hit;
	tlb_entry_t [tlb_assoc-1:0] ways;

	// ==================================================
	// TLB storage and compare
	// ==================================================

	tlb_lookup tlb_lookup_inst (
		.clk(clk),
		.rst(rst),
		.vadr(vadr),
		.asid(asid),
		.fill(fill),
		.fill_v(fill_v),
		.flush_v(flush_v),
		.hit(hit),
		.ways(ways)
	);

	// ==================================================
	// Address selection and miss reporting
	// ==================================================

	tlb_adr_mux tlb_adr_mux_inst (
		.clk(clk),
		.rst(rst),
		.idle(idle),
		.paging_en(paging_en),
		.hit(hit),
		.ways(ways),
		.id(id),
		.asid(asid),
		.vadr(vadr),
		.vadr_v(vadr_v),
		.padr(padr),
		.padr_v(padr_v),
		.fill_ready(fill_ready),
		.miss(miss),
		.miss_v(miss_v)
	);

endmodule

// ==== mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb;
	import mmu_pkg::*;

	// Cycles a request may take before it counts as lost
	localparam int req_timeout = 20;
	localparam int ready_timeout = 20;
	// Quiet cycles after a paging switch
	localparam int settle_cycles = 3;

	logic clk;
	logic rst;
	virtual_address_t vadr;
	logic vadr_v;
	asid_t asid;
	req_id_t id;
	logic paging_en;
	logic idle;
	tlb_fill_t fill;
	logic fill_v;
	logic flush_v;
	physical_address_t padr;
	logic padr_v;
	tlb_miss_t miss;
	logic miss_v;
	logic fill_ready;

	int mismatches;
	int failures;
	int translations;
	// VPN last put on the bus, to spot the first cycle of a new page
	logic [vpn_bits-1:0] last_vpn;
	// Case file parsing
	int fd;
	int n;
	logic [8*120-1:0] line_buf;
	logic [7:0] op;
	logic [7:0] kind;
	logic [31:0] f1, f2, f3, f4;

	mmu_top mmu_top_inst (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		failures++;
	endtask

	// ==================================================
	// Operations
	// ==================================================

	// Fill and flush may only be strobed while the TLB accepts writes
	task automatic wait_fill_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!fill_ready && cycles < ready_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!fill_ready)
			report_failure("fill_ready stayed low until the timeout");
	endtask

	task automatic write_entry(input asid_t a, input logic [vpn_bits-1:0] vpn,
			input logic [ppn_bits-1:0] ppn);
		wait_fill_ready();
		@(posedge clk);
		fill <= '{asid: a, vpn: vpn, ppn: ppn};
		fill_v <= 1'b1;
		@(posedge clk);
		fill_v <= 1'b0;
	endtask

	task automatic flush_tlb();
		wait_fill_ready();
		@(posedge clk);
		flush_v <= 1'b1;
		@(posedge clk);
		flush_v <= 1'b0;
	endtask

	// No request is pending, so the switch itself must not produce a result
	task automatic switch_paging(input logic en);
		@(posedge clk);
		paging_en <= en;
		repeat (settle_cycles) begin
			@(negedge clk);
			if (padr_v !== 1'b0)
				report_mismatch("padr_v", padr_v, 0);
			if (miss_v !== 1'b0)
				report_mismatch("miss_v", miss_v, 0);
		end
		// With paging off the TLB is always writable
		if (!en && fill_ready !== 1'b1)
			report_mismatch("fill_ready", fill_ready, 1);
	endtask

	// Holds one request until the DUT answers, then checks the answer
	task automatic translate(input asid_t a, input req_id_t i, input logic [31:0] va,
			input logic [7:0] k, input logic [31:0] exp_padr);
		int cycles;
		logic done;
		logic new_page;
		new_page = va[vadr_bits-1:log_pagesize] != last_vpn;
		last_vpn = va[vadr_bits-1:log_pagesize];
		@(posedge clk);
		vadr <= va;
		asid <= a;
		id <= i;
		vadr_v <= 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < req_timeout) begin
			@(negedge clk);
			cycles++;
			// The lookup on a new page has not settled yet
			if (cycles == 1 && new_page && miss_v !== 1'b0)
				report_mismatch("miss_v", miss_v, 0);
			done = padr_v || miss_v;
		end
		translations++;
		if (!done) begin
			report_failure("request got neither padr_v nor miss_v before the timeout");
		end else if (k == "M") begin
			if (miss_v !== 1'b1)
				report_mismatch("miss_v", miss_v, 1);
			if (miss.id !== i)
				report_mismatch("miss.id", miss.id, i);
			if (miss.asid !== a)
				report_mismatch("miss.asid", miss.asid, a);
			if (miss.vadr.raw !== va)
				report_mismatch("miss.vadr", miss.vadr.raw, va);
		end else begin
			if (padr_v !== 1'b1)
				report_mismatch("padr_v", padr_v, 1);
			if (padr !== exp_padr)
				report_mismatch("padr", padr, exp_padr);
			// Hits and pass-through both leave the TLB writable while idle
			if (fill_ready !== 1'b1)
				report_mismatch("fill_ready", fill_ready, 1);
		end
		@(posedge clk);
		vadr_v <= 1'b0;
	endtask

	task automatic run_line();
		int fields;
		case (op)
			"F": begin
				fields = $sscanf(line_buf, "%s %h %h %h", op, f1, f2, f3);
				if (fields != 4)
					report_failure("fill line in the case file has missing fields");
				else
					write_entry(f1[15:0], f2[vpn_bits-1:0], f3[ppn_bits-1:0]);
			end
			"X": flush_tlb();
			"P": begin
				fields = $sscanf(line_buf, "%s %h", op, f1);
				if (fields != 2)
					report_failure("paging line in the case file has no value");
				else
					switch_paging(f1[0]);
			end
			"T": begin
				fields = $sscanf(line_buf, "%s %h %h %h %s %h", op, f1, f2, f3, kind, f4);
				if (fields != 6)
					report_failure("translate line in the case file has missing fields");
				else
					translate(f1[15:0], f2[7:0], f3, kind, f4);
			end
			default: report_failure("unknown operation letter in the case file");
		endcase
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		mismatches = 0;
		failures = 0;
		translations = 0;
		last_vpn = '0;
		rst <= 1'b1;
		vadr <= '0;
		vadr_v <= 1'b0;
		asid <= '0;
		id <= '0;
		paging_en <= 1'b0;
		idle <= 1'b1;
		fill <= '0;
		fill_v <= 1'b0;
		flush_v <= 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// Outputs straight after reset
		@(negedge clk);
		if (fill_ready !== 1'b1)
			report_mismatch("fill_ready", fill_ready, 1);
		if (padr_v !== 1'b0)
			report_mismatch("padr_v", padr_v, 0);
		if (miss_v !== 1'b0)
			report_mismatch("miss_v", miss_v, 0);

		// The TLB is not writable while the requester is busy
		@(posedge clk);
		idle <= 1'b0;
		repeat (2) @(negedge clk);
		if (fill_ready !== 1'b0)
			report_mismatch("fill_ready", fill_ready, 0);
		@(posedge clk);
		idle <= 1'b1;
		repeat (2) @(negedge clk);
		if (fill_ready !== 1'b1)
			report_mismatch("fill_ready", fill_ready, 1);

		fd = $fopen("mmu_cases.txt", "r");
		if (fd == 0) begin
			report_failure("mmu_cases.txt could not be opened");
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				op = "#";
				n = $fgets(line_buf, fd);
				// Blank and comment lines leave op at '#'
				if (n > 0)
					n = $sscanf(line_buf, "%s", op);
				if (n > 0 && op != "#")
					run_line();
			end
			$fclose(fd);
		end
		if (translations == 0)
			report_failure("no translation was read from the case file");

		$display("Ran %0d translations: %0d mismatches, %0d other errors",
			translations, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== mmu_cases.txt ====
# One operation per line, fields in hex: F asid vpn ppn | X | P paging_en
# T asid id vadr kind padr, where kind is H (hit), M (miss) or P (pass-through)
P 1
T 0001 01 00024abc M 00000000
F 0001 00012 00345
T 0001 02 00024abc H 0068aabc
T 0002 03 00024abc M 00000000
T 0001 04 00026000 M 00000000
F 0002 00012 00456
T 0002 05 00024abc H 008acabc
T 0001 06 00024010 H 0068a010
F 0001 00005 00100
F 0001 00015 00101
F 0001 00025 00102
F 0001 00035 00103
T 0001 07 0000a010 M 00000000
T 0001 08 0002a010 H 00202010
T 0001 09 0004a010 H 00204010
T 0001 0a 0006a010 H 00206010
X
T 0001 0b 00024abc M 00000000
T 0002 0c 00024abc M 00000000
T 0001 0d 0004a010 M 00000000
P 0
T 0005 0e 12345678 P 12345678
T 0005 0f deadbeef P deadbeef
P 1
T 0001 10 0002a010 M 00000000
F 0001 00015 00777
T 0001 11 0002a010 H 00eee010
T 0001 12 0002bfff H 00eeffff

// ==== mmu.f ====
mmu_pkg.sv
tlb_lookup.sv
tlb_adr_mux.sv
mmu_top.sv
mmu_tb.sv

// ==== run_mmu.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mmu.f --top-module mmu_tb -o mmu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/mmu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

# The testbench prints its verdict into the log
if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi
echo "Simulation passed"
exit 0
